//--- Makefile
VERILATOR ?= verilator
TOP       ?= fib_tb
FLIST     ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

//--- all.f
source/ndn_pkg.sv
source/fib_pkg.sv
source/prefix_hash.sv
source/fib_valid_table.sv
source/fib_table_arbiter.sv
source/fib_learn.sv
source/fib_lpm_lookup.sv
source/data_forwarder.sv
source/fib_top.sv
sim/fib_chk.sv
sim/fib_tb.sv

//--- sim/fib_chk.sv
`default_nettype none
`timescale 1ns/1ps

module fib_chk (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                learn_req_valid,
    input wire logic                lookup_req_valid,
    input wire fib_pkg::table_req_t learn_req,
    input wire fib_pkg::table_req_t lookup_req,
    input wire logic                learn_gnt,
    input wire logic                lookup_gnt,
    input wire logic                lookup_done,
    input wire logic                data_valid,
    input wire logic                pit_query_valid,
    input wire logic                pit_reply_valid,
    input wire logic                pit_accept,
    input wire logic                pit_byte_valid
);

    // Last PIT verdict seen on the reply strobe
    logic accept_seen;

    always_ff @(posedge clk) begin
        if (rst) begin
            accept_seen <= 1'b0;
        end else if (pit_reply_valid) begin
            accept_seen <= pit_accept;
        end
    end

    // One table user per cycle
    a_one_gnt: assert property (@(posedge clk) disable iff (rst)
        !(learn_gnt && lookup_gnt))
        else $error("both engines granted in one cycle");

    // Held requests must not move before the grant
    a_learn_hold: assert property (@(posedge clk) disable iff (rst)
        learn_req_valid && !learn_gnt |=> learn_req_valid && $stable(learn_req))
        else $error("learn request changed while waiting for grant");

    a_lookup_hold: assert property (@(posedge clk) disable iff (rst)
        lookup_req_valid && !lookup_gnt |=> lookup_req_valid && $stable(lookup_req))
        else $error("lookup request changed while waiting for grant");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        lookup_done |=> !lookup_done)
        else $error("lookup_done longer than one cycle");

    // Query strobe is data_valid delayed by one cycle
    a_query_follows: assert property (@(posedge clk) disable iff (rst)
        data_valid |=> pit_query_valid)
        else $error("no PIT query one cycle after data_valid");

    a_query_cause: assert property (@(posedge clk) disable iff (rst)
        pit_query_valid |-> $past(data_valid))
        else $error("PIT query without a data arrival");

    a_byte_accepted: assert property (@(posedge clk) disable iff (rst)
        pit_byte_valid |-> accept_seen)
        else $error("payload byte forwarded without an accept");

endmodule

`default_nettype wire

//--- sim/fib_tb.sv
`default_nettype none
`timescale 1ns/1ps

module fib_tb;

    localparam int payload_len = 16;
    localparam int wait_limit  = 400;

    logic                    clk;
    logic                    rst;
    logic                    data_valid;
    ndn_pkg::name_t          data_name;
    logic                    data_byte_valid;
    ndn_pkg::payload_byte_t  data_byte;
    logic                    lookup_valid;
    ndn_pkg::name_t          lookup_name;
    logic                    pit_reply_valid;
    logic                    pit_accept;
    logic                    pit_query_valid;
    ndn_pkg::name_t          pit_query_name;
    logic                    pit_byte_valid;
    ndn_pkg::payload_byte_t  pit_byte;
    logic                    lookup_done;
    fib_pkg::lookup_result_t lookup_result;

    // Reference copy of the valid bits
    bit                      model [64][1024];
    ndn_pkg::payload_byte_t  rx_q [$];
    integer                  seed = 32'h9f0c;
    int                      errors = 0;
    int                      tests = 0;

    fib_top #(.payload_len(payload_len)) i_dut (.*);

    bind fib_top fib_chk i_chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Hard stop for a stuck run
    initial begin
        #(40 * 100000);
        $display("simulation ran past its time limit");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Forwarded bytes, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && pit_byte_valid) begin
            rx_q.push_back(pit_byte);
        end
    end

    // Bit i of the prefix lands on bucket bit i mod 10 when kept
    function automatic logic [9:0] bucket_of(logic [63:0] p, logic [5:0] len);
        logic [9:0] b;
        b = '0;
        for (int i = 0; i < 64; i++) begin
            if (i >= 64 - int'(len)) begin
                b[i % 10] = b[i % 10] ^ p[i];
            end
        end
        b[5:0] = b[5:0] ^ len;
        return b;
    endfunction

    function automatic logic [70:0] expected_result(ndn_pkg::name_t n);
        for (int l = int'(n.len); l >= 0; l--) begin
            if (model[l][bucket_of(n.prefix, 6'(l))]) begin
                return {1'b1, n.prefix, 6'(l)};
            end
        end
        return {1'b0, n.prefix, 6'd0};
    endfunction

    function automatic ndn_pkg::name_t random_name(logic [5:0] len);
        ndn_pkg::name_t n;
        n.prefix = {$random(seed), $random(seed)};
        n.len    = len;
        return n;
    endfunction

    task automatic compare_value(string test, logic [70:0] exp, logic [70:0] act);
        assert (exp === act) else begin
            $display("MISMATCH %s: expected %h, actual %h", test, exp, act);
            errors++;
        end
    endtask

    task automatic note_timeout(string what);
        $display("%s: timed out", what);
        errors++;
    endtask

    task automatic run_lookup(string test, ndn_pkg::name_t n);
        logic [70:0] exp;
        int          cnt;
        exp = expected_result(n);
        @(posedge clk);
        #2;
        lookup_valid = 1'b1;
        lookup_name  = n;
        @(posedge clk);
        #2;
        lookup_valid = 1'b0;
        cnt = 0;
        while (!lookup_done && cnt < wait_limit) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!lookup_done) begin
            note_timeout({test, " waiting for lookup_done"});
        end else begin
            compare_value(test, exp, lookup_result);
        end
    endtask

    // One arrival with its PIT exchange and payload
    task automatic send_packet(string test, ndn_pkg::name_t n, logic accept);
        ndn_pkg::payload_byte_t base;
        ndn_pkg::payload_byte_t exp_byte;
        int                     cnt;
        base = 8'($random(seed));
        rx_q.delete();
        @(posedge clk);
        #2;
        data_valid = 1'b1;
        data_name  = n;
        @(posedge clk);
        #2;
        data_valid = 1'b0;
        cnt = 0;
        while (!pit_query_valid && cnt < wait_limit) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!pit_query_valid) begin
            note_timeout({test, " waiting for pit_query_valid"});
        end else begin
            compare_value({test, " query"}, 71'(n), 71'(pit_query_name));
        end
        @(posedge clk);
        #2;
        pit_reply_valid = 1'b1;
        pit_accept      = accept;
        @(posedge clk);
        #2;
        pit_reply_valid = 1'b0;
        for (int i = 0; i < payload_len; i++) begin
            data_byte_valid = 1'b1;
            data_byte       = base + 8'(i);
            @(posedge clk);
            #2;
        end
        data_byte_valid = 1'b0;
        repeat (3) @(posedge clk);
        compare_value({test, " byte count"}, accept ? 71'(payload_len) : 71'd0,
                      71'(rx_q.size()));
        if (accept && rx_q.size() == payload_len) begin
            for (int i = 0; i < payload_len; i++) begin
                // Payload bytes wrap at 8 bits
                exp_byte = base + 8'(i);
                compare_value({test, " byte"}, 71'(exp_byte), 71'(rx_q[i]));
            end
        end
        model[n.len][bucket_of(n.prefix, n.len)] = 1'b1;
    endtask

    task automatic end_test(string test, int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", test);
        end else begin
            $display("test %s: failed", test);
        end
    endtask

    initial begin
        ndn_pkg::name_t p;
        ndn_pkg::name_t q;
        int             e;
        rst = 1'b1;
        data_valid = 1'b0;
        data_name = '0;
        data_byte_valid = 1'b0;
        data_byte = '0;
        lookup_valid = 1'b0;
        lookup_name = '0;
        pit_reply_valid = 1'b0;
        pit_accept = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        e = errors;
        for (int i = 0; i < 4; i++) begin
            run_lookup("empty", random_name(6'($random(seed))));
        end
        end_test("empty", e);

        e = errors;
        p = random_name(6'd33);
        send_packet("exact", p, 1'b1);
        run_lookup("exact", p);
        end_test("exact", e);

        e = errors;
        p = random_name(6'd8);
        send_packet("longest", p, 1'b0);
        p.len = 6'd20;
        send_packet("longest", p, 1'b1);
        p.len = 6'd40;
        run_lookup("longest 40", p);
        p.len = 6'd12;
        run_lookup("longest 12", p);
        for (int i = 0; i < 4; i++) begin
            send_packet("longest extra", random_name(6'($random(seed))), i[0]);
            run_lookup("longest random", random_name(6'($random(seed))));
        end
        end_test("longest", e);

        e = errors;
        p.len = 6'd20;
        q = random_name(6'd30);
        fork
            send_packet("contention", q, 1'b1);
            run_lookup("contention", p);
        join
        run_lookup("contention after", q);
        // Learn wins the first tie, a lone learn hands the next tie to lookup
        send_packet("contention", random_name(6'd24), 1'b0);
        q = random_name(6'd28);
        fork
            send_packet("contention late", q, 1'b1);
            run_lookup("contention late", p);
        join
        run_lookup("contention late after", q);
        end_test("contention", e);

        e = errors;
        send_packet("pit accept", random_name(6'd50), 1'b1);
        end_test("pit accept", e);

        e = errors;
        send_packet("pit reject", random_name(6'd17), 1'b0);
        send_packet("pit after reject", random_name(6'd18), 1'b1);
        end_test("pit reject", e);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/data_forwarder.sv
`default_nettype none
`timescale 1ns/1ps

module data_forwarder #(
    parameter int payload_len = 1024
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  data_valid,
    input  ndn_pkg::name_t        data_name,
    input  logic                  data_byte_valid,
    input  ndn_pkg::payload_byte_t data_byte,
    output logic                  pit_query_valid,
    output ndn_pkg::name_t        pit_query_name,
    input  logic                  pit_reply_valid,
    input  logic                  pit_accept,
    output logic                  pit_byte_valid,
    output ndn_pkg::payload_byte_t pit_byte
);

    localparam int cnt_w = $clog2(payload_len + 1);

    typedef enum logic [1:0] {s_idle, s_wait, s_pass} state_t;

    state_t           state;
    // PIT verdict for the current packet
    logic             accept_q;
    logic [cnt_w-1:0] byte_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= s_idle;
            pit_query_valid <= 1'b0;
            pit_byte_valid  <= 1'b0;
            accept_q        <= 1'b0;
            byte_cnt        <= '0;
        end else begin
            pit_query_valid <= 1'b0;
            pit_byte_valid  <= 1'b0;
            case (state)
                s_idle: begin
                    // Ask the PIT whether this data was requested
                    if (data_valid) begin
                        pit_query_valid <= 1'b1;
                        state           <= s_wait;
                    end
                end
                s_wait: begin
                    // No limit on the PIT answer time
                    if (pit_reply_valid) begin
                        accept_q <= pit_accept;
                        byte_cnt <= '0;
                        state    <= s_pass;
                    end
                end
                s_pass: begin
                    if (data_byte_valid) begin
                        // Rejected bytes are counted but dropped
                        pit_byte_valid <= accept_q;
                        byte_cnt       <= byte_cnt + 1'b1;
                        if (byte_cnt == cnt_w'(payload_len - 1)) begin
                            state <= s_idle;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && data_valid) begin
            pit_query_name <= data_name;
        end
        if (data_byte_valid) begin
            pit_byte <= data_byte;
        end
    end

endmodule

`default_nettype wire

//--- source/fib_learn.sv
`default_nettype none
`timescale 1ns/1ps

module fib_learn (
    input  logic                clk,
    input  logic                rst,
    input  logic                data_valid,
    input  ndn_pkg::name_t      data_name,
    input  logic                hash_valid,
    input  fib_pkg::bucket_t    hash_bucket,
    output logic                hash_in_valid,
    output ndn_pkg::name_t      hash_in_name,
    output logic                req_valid,
    output fib_pkg::table_req_t req,
    input  logic                gnt
);

    // Row of the entry being learned
    ndn_pkg::prefix_len_t row_q;

    // Arrival goes straight into the hash unit
    assign hash_in_valid = data_valid;
    assign hash_in_name  = data_name;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (hash_valid) begin
            req_valid <= 1'b1;
        end else if (gnt) begin
            // Write done this cycle
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid) begin
            row_q <= data_name.len;
        end
        // Write request built from the returned bucket
        if (hash_valid) begin
            req.we     <= 1'b1;
            req.row    <= row_q;
            req.bucket <= hash_bucket;
        end
    end

endmodule

`default_nettype wire

//--- source/fib_lpm_lookup.sv
`default_nettype none
`timescale 1ns/1ps

module fib_lpm_lookup (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    lookup_valid,
    input  ndn_pkg::name_t          lookup_name,
    output logic                    hash_in_valid,
    output ndn_pkg::name_t          hash_in_name,
    input  logic                    hash_valid,
    input  fib_pkg::bucket_t        hash_bucket,
    output logic                    req_valid,
    output fib_pkg::table_req_t     req,
    input  logic                    gnt,
    input  logic                    rd_bit,
    output logic                    done,
    output fib_pkg::lookup_result_t result
);

    typedef enum logic [1:0] {s_idle, s_hash, s_req, s_check} state_t;

    state_t                state;
    ndn_pkg::name_prefix_t prefix_q;
    // Length under probe
    ndn_pkg::prefix_len_t  len_q;
    fib_pkg::bucket_t      bucket_q;
    logic                  last_probe;

    assign hash_in_valid = (state == s_hash);
    assign req_valid     = (state == s_req);
    // Stop on a hit or when length 0 misses
    assign last_probe    = rd_bit || (len_q == '0);

    always_comb begin
        hash_in_name.prefix = prefix_q;
        hash_in_name.len    = len_q;
        // Read request, bucket is fresh from the hash in the first cycle
        req.we  = 1'b0;
        req.row = len_q;
        if (hash_valid) begin
            req.bucket = hash_bucket;
        end else begin
            req.bucket = bucket_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                s_idle: begin
                    if (lookup_valid) begin
                        state <= s_hash;
                    end
                end
                s_hash: state <= s_req;
                s_req: begin
                    if (gnt) begin
                        state <= s_check;
                    end
                end
                s_check: begin
                    if (last_probe) begin
                        done  <= 1'b1;
                        state <= s_idle;
                    end else begin
                        state <= s_hash;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && lookup_valid) begin
            prefix_q <= lookup_name.prefix;
            len_q    <= lookup_name.len;
        end else if (state == s_check && !last_probe) begin
            // Next shorter prefix
            len_q <= len_q - 1'b1;
        end
        if (hash_valid) begin
            bucket_q <= hash_bucket;
        end
        // Result reports the original prefix and the probed length
        if (state == s_check) begin
            result.hit         <= rd_bit;
            result.name.prefix <= prefix_q;
            result.name.len    <= len_q;
        end
    end

endmodule

`default_nettype wire

//--- source/fib_pkg.sv
`default_nettype none

package fib_pkg;

    // Hash bucket, one column of the valid-bit table
    // Hash rule:
    //   zero the prefix bits below the length (keep the top len bits)
    //   XOR-fold the 64 bits in 10-bit chunks, chunk 0 is prefix[9:0]
    //   the last chunk is prefix[63:60] with zeros above it
    //   XOR the length into bucket[5:0]
    typedef logic [9:0] bucket_t;

    // Table access, row is the prefix length
    typedef struct packed {
        logic                 we;
        ndn_pkg::prefix_len_t row;
        bucket_t              bucket;
    } table_req_t;

    // Longest-prefix-match outcome
    typedef struct packed {
        logic           hit;
        ndn_pkg::name_t name;
    } lookup_result_t;

endpackage

`default_nettype wire

//--- source/fib_table_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module fib_table_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                learn_req_valid,
    input  logic                lookup_req_valid,
    input  fib_pkg::table_req_t learn_req,
    input  fib_pkg::table_req_t lookup_req,
    output logic                learn_gnt,
    output logic                lookup_gnt,
    output logic                table_req_valid,
    output fib_pkg::table_req_t table_req
);

    // High when lookup wins the next tie
    logic lookup_first;

    always_comb begin
        learn_gnt  = learn_req_valid && (!lookup_req_valid || !lookup_first);
        lookup_gnt = lookup_req_valid && (!learn_req_valid || lookup_first);
        table_req_valid = learn_gnt || lookup_gnt;
        // Winner drives the table port
        if (lookup_gnt) begin
            table_req = lookup_req;
        end else begin
            table_req = learn_req;
        end
    end

    // Turn passes to the engine not served last
    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_first <= 1'b0;
        end else if (learn_gnt) begin
            lookup_first <= 1'b1;
        end else if (lookup_gnt) begin
            lookup_first <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/fib_top.sv
`default_nettype none
`timescale 1ns/1ps

module fib_top #(
    parameter int payload_len = 1024
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    data_valid,
    input  ndn_pkg::name_t          data_name,
    input  logic                    data_byte_valid,
    input  ndn_pkg::payload_byte_t  data_byte,
    input  logic                    lookup_valid,
    input  ndn_pkg::name_t          lookup_name,
    input  logic                    pit_reply_valid,
    input  logic                    pit_accept,
    output logic                    pit_query_valid,
    output ndn_pkg::name_t          pit_query_name,
    output logic                    pit_byte_valid,
    output ndn_pkg::payload_byte_t  pit_byte,
    output logic                    lookup_done,
    output fib_pkg::lookup_result_t lookup_result
);

    // Learn side hash
    logic                learn_hash_in_valid;
    ndn_pkg::name_t      learn_hash_in_name;
    logic                learn_hash_valid;
    fib_pkg::bucket_t    learn_bucket;
    // Lookup side hash
    logic                lookup_hash_in_valid;
    ndn_pkg::name_t      lookup_hash_in_name;
    logic                lookup_hash_valid;
    fib_pkg::bucket_t    lookup_bucket;
    // Engine requests and grants
    logic                learn_req_valid;
    logic                lookup_req_valid;
    fib_pkg::table_req_t learn_req;
    fib_pkg::table_req_t lookup_req;
    logic                learn_gnt;
    logic                lookup_gnt;
    // Table port
    logic                table_req_valid;
    fib_pkg::table_req_t table_req;
    logic                rd_bit;

    prefix_hash i_learn_hash (
        .clk(clk), .rst(rst),
        .in_valid(learn_hash_in_valid), .in_name(learn_hash_in_name),
        .out_valid(learn_hash_valid), .bucket(learn_bucket)
    );

    prefix_hash i_lookup_hash (
        .clk(clk), .rst(rst),
        .in_valid(lookup_hash_in_valid), .in_name(lookup_hash_in_name),
        .out_valid(lookup_hash_valid), .bucket(lookup_bucket)
    );

    fib_learn i_learn (
        .clk(clk), .rst(rst),
        .data_valid(data_valid), .data_name(data_name),
        .hash_valid(learn_hash_valid), .hash_bucket(learn_bucket),
        .hash_in_valid(learn_hash_in_valid), .hash_in_name(learn_hash_in_name),
        .req_valid(learn_req_valid), .req(learn_req), .gnt(learn_gnt)
    );

    fib_lpm_lookup i_lookup (
        .clk(clk), .rst(rst),
        .lookup_valid(lookup_valid), .lookup_name(lookup_name),
        .hash_in_valid(lookup_hash_in_valid), .hash_in_name(lookup_hash_in_name),
        .hash_valid(lookup_hash_valid), .hash_bucket(lookup_bucket),
        .req_valid(lookup_req_valid), .req(lookup_req), .gnt(lookup_gnt),
        .rd_bit(rd_bit), .done(lookup_done), .result(lookup_result)
    );

    fib_table_arbiter i_arbiter (
        .clk(clk), .rst(rst),
        .learn_req_valid(learn_req_valid), .lookup_req_valid(lookup_req_valid),
        .learn_req(learn_req), .lookup_req(lookup_req),
        .learn_gnt(learn_gnt), .lookup_gnt(lookup_gnt),
        .table_req_valid(table_req_valid), .table_req(table_req)
    );

    fib_valid_table i_table (
        .clk(clk), .rst(rst),
        .req_valid(table_req_valid), .req(table_req), .rd_bit(rd_bit)
    );

    data_forwarder #(
        .payload_len(payload_len)
    ) i_forwarder (
        .clk(clk), .rst(rst),
        .data_valid(data_valid), .data_name(data_name),
        .data_byte_valid(data_byte_valid), .data_byte(data_byte),
        .pit_query_valid(pit_query_valid), .pit_query_name(pit_query_name),
        .pit_reply_valid(pit_reply_valid), .pit_accept(pit_accept),
        .pit_byte_valid(pit_byte_valid), .pit_byte(pit_byte)
    );

endmodule

`default_nettype wire

//--- source/fib_valid_table.sv
`default_nettype none
`timescale 1ns/1ps

module fib_valid_table (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  fib_pkg::table_req_t req,
    output logic                rd_bit
);

    localparam int rows = 2 ** $bits(ndn_pkg::prefix_len_t);
    localparam int cols = 2 ** $bits(fib_pkg::bucket_t);

    // One row per prefix length, one bit per bucket
    logic [cols-1:0]      mem [rows];
    // Rows not yet wiped since reset
    logic [rows-1:0]      pending;
    ndn_pkg::prefix_len_t clr_row;
    logic                 wr;

    assign wr = req_valid && req.we;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '1;
            clr_row <= '0;
        end else begin
            // Sweep one row per cycle
            if (pending[clr_row]) begin
                mem[clr_row] <= '0;
            end
            // First write to a stale row wipes it too
            if (wr && pending[req.row]) begin
                mem[req.row] <= '0;
            end
            if (wr) begin
                mem[req.row][req.bucket] <= 1'b1;
                pending[req.row] <= 1'b0;
            end
            pending[clr_row] <= 1'b0;
            clr_row <= clr_row + 1'b1;
        end
    end

    // Stale rows read as empty
    always_ff @(posedge clk) begin
        rd_bit <= mem[req.row][req.bucket] && !pending[req.row];
    end

endmodule

`default_nettype wire

//--- source/ndn_pkg.sv
`default_nettype none

package ndn_pkg;

    // Name prefix, bit 63 is the first name bit
    // Bits below the prefix length carry no meaning
    typedef logic [63:0] name_prefix_t;

    // Prefix length in bits, 0 to 63
    typedef logic [5:0] prefix_len_t;

    // Prefix and its length travel together
    // Used for data arrivals, lookups, PIT queries and results
    typedef struct packed {
        name_prefix_t prefix;
        prefix_len_t  len;
    } name_t;

    // One byte of data payload
    typedef logic [7:0] payload_byte_t;

endpackage

`default_nettype wire

//--- source/prefix_hash.sv
`default_nettype none
`timescale 1ns/1ps

module prefix_hash (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  ndn_pkg::name_t   in_name,
    output logic             out_valid,
    output fib_pkg::bucket_t bucket
);

    ndn_pkg::name_prefix_t keep_mask;
    logic [69:0]           padded;
    fib_pkg::bucket_t      folded;

    always_comb begin
        // Only the top len bits take part in the hash
        keep_mask = ~({64{1'b1}} >> in_name.len);
        // Pad to seven full chunks
        padded = {6'b0, in_name.prefix & keep_mask};
        folded = '0;
        for (int i = 0; i < 7; i++) begin
            folded = folded ^ padded[i*10 +: 10];
        end
        // Length goes into the low bits
        folded[5:0] = folded[5:0] ^ in_name.len;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
        bucket <= folded;
    end

endmodule

`default_nettype wire
